/* sources.f */
+incdir+tb
hw/rv_isa_pkg.sv
hw/tomasulo_pkg.sv
hw/rename_issue.sv
hw/reservation_station.sv
hw/alu_exec.sv
hw/tomasulo_alu_core.sv
tb/tb_tomasulo_alu_core.sv

/* run_sim.sh */
#!/bin/sh
# Build the core testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log
TOP=tb_tomasulo_alu_core

verilator --binary --timing -f sources.f --top-module "$TOP" -Mdir obj_dir > "$BUILD_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
	cat "$BUILD_LOG"
	echo "Verilator build failed with status $status"
	exit 1
fi

./obj_dir/V"$TOP" > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"

# Result comes from the log
if grep -q "TEST FAILED" "$SIM_LOG"; then
	exit 1
fi
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi
exit 0

/* tb/tb_stimulus.svh */
`ifndef TB_STIMULUS_SVH
`define TB_STIMULUS_SVH

localparam int NUM_INST = 28;                          // Program length

typedef struct packed {
	rv_isa_pkg::alu_op_e   op;
	rv_isa_pkg::reg_addr_t rd;
	rv_isa_pkg::reg_addr_t rs1;
	rv_isa_pkg::reg_addr_t rs2;
	rv_isa_pkg::word_t     imm;
	logic                  use_imm;                    // Operand b from imm
	logic                  burst;                      // No idle gap after this one
} inst_t;

inst_t             prog     [NUM_INST];
rv_isa_pkg::word_t exp_res  [NUM_INST];                // Result of each instruction
rv_isa_pkg::word_t exp_regs [rv_isa_pkg::NUM_REGS];    // Final architectural state

task automatic set_inst(input int idx, input rv_isa_pkg::alu_op_e op, input int rd,
                        input int rs1, input int rs2, input rv_isa_pkg::word_t imm,
                        input logic use_imm, input logic burst);
	prog[idx].op      = op;
	prog[idx].rd      = rv_isa_pkg::reg_addr_t'(rd);
	prog[idx].rs1     = rv_isa_pkg::reg_addr_t'(rs1);
	prog[idx].rs2     = rv_isa_pkg::reg_addr_t'(rs2);
	prog[idx].imm     = imm;
	prog[idx].use_imm = use_imm;
	prog[idx].burst   = burst;
endtask

task automatic load_program();
	// Arguments are idx, op, rd, rs1, rs2, imm, use_imm and burst
	set_inst(0,  rv_isa_pkg::alu_add,  1,  0,  0,  32'h1234_5678, 1'b1, 1'b0);
	set_inst(1,  rv_isa_pkg::alu_add,  2,  0,  0,  32'hFFFF_FFFB, 1'b1, 1'b0);
	set_inst(2,  rv_isa_pkg::alu_add,  3,  0,  0,  32'h0000_0007, 1'b1, 1'b0);
	set_inst(3,  rv_isa_pkg::alu_sub,  4,  1,  2,  32'h0000_0000, 1'b0, 1'b0);
	set_inst(4,  rv_isa_pkg::alu_and,  5,  1,  0,  32'h0F0F_0F0F, 1'b1, 1'b0);
	set_inst(5,  rv_isa_pkg::alu_or,   6,  2,  3,  32'h0000_0000, 1'b0, 1'b0);
	set_inst(6,  rv_isa_pkg::alu_xor,  7,  1,  0,  32'hFFFF_0000, 1'b1, 1'b0);
	set_inst(7,  rv_isa_pkg::alu_sll,  8,  1,  3,  32'h0000_0000, 1'b0, 1'b0);
	set_inst(8,  rv_isa_pkg::alu_srl,  9,  2,  0,  32'h0000_0024, 1'b1, 1'b0); // Shift by 4
	set_inst(9,  rv_isa_pkg::alu_sra,  10, 2,  3,  32'h0000_0000, 1'b0, 1'b0);
	set_inst(10, rv_isa_pkg::alu_slt,  11, 2,  3,  32'h0000_0000, 1'b0, 1'b0);
	set_inst(11, rv_isa_pkg::alu_sltu, 12, 2,  3,  32'h0000_0000, 1'b0, 1'b0);
	set_inst(12, rv_isa_pkg::alu_xor,  13, 4,  1,  32'h0000_0000, 1'b0, 1'b0); // RAW chain
	set_inst(13, rv_isa_pkg::alu_sll,  13, 13, 0,  32'h0000_0003, 1'b1, 1'b0);
	set_inst(14, rv_isa_pkg::alu_sub,  14, 13, 4,  32'h0000_0000, 1'b0, 1'b0);
	set_inst(15, rv_isa_pkg::alu_add,  16, 0,  0,  32'd100,       1'b1, 1'b0); // WAW pair
	set_inst(16, rv_isa_pkg::alu_add,  17, 16, 0,  32'd1,         1'b1, 1'b0);
	set_inst(17, rv_isa_pkg::alu_add,  16, 0,  0,  32'd200,       1'b1, 1'b0);
	set_inst(18, rv_isa_pkg::alu_add,  18, 14, 13, 32'h0000_0000, 1'b0, 1'b1); // Fill station
	set_inst(19, rv_isa_pkg::alu_sra,  18, 18, 3,  32'h0000_0000, 1'b0, 1'b1);
	set_inst(20, rv_isa_pkg::alu_or,   19, 18, 2,  32'h0000_0000, 1'b0, 1'b1);
	set_inst(21, rv_isa_pkg::alu_and,  20, 18, 1,  32'h0000_0000, 1'b0, 1'b1);
	set_inst(22, rv_isa_pkg::alu_add,  21, 18, 18, 32'h0000_0000, 1'b0, 1'b1);
	set_inst(23, rv_isa_pkg::alu_slt,  22, 18, 0,  32'h0000_0000, 1'b0, 1'b1);
	set_inst(24, rv_isa_pkg::alu_sltu, 23, 18, 2,  32'h0000_0000, 1'b0, 1'b1);
	set_inst(25, rv_isa_pkg::alu_xor,  24, 18, 7,  32'h0000_0000, 1'b0, 1'b0);
	set_inst(26, rv_isa_pkg::alu_add,  0,  1,  2,  32'h0000_0000, 1'b0, 1'b0); // Writes x0
	set_inst(27, rv_isa_pkg::alu_add,  25, 0,  0,  32'h0000_0003, 1'b1, 1'b0);
endtask

function automatic rv_isa_pkg::word_t alu_ref(input rv_isa_pkg::alu_op_e op,
                                              input rv_isa_pkg::word_t a,
                                              input rv_isa_pkg::word_t b);
	logic [4:0] sh;
	logic       lt;
	sh = b[4:0];
	lt = (a[31] != b[31]) ? a[31] : (a < b);           // Signed less than from sign bits
	case (op)
		rv_isa_pkg::alu_add:  return a + b;
		rv_isa_pkg::alu_sub:  return a - b;
		rv_isa_pkg::alu_and:  return a & b;
		rv_isa_pkg::alu_or:   return a | b;
		rv_isa_pkg::alu_xor:  return a ^ b;
		rv_isa_pkg::alu_sll:  return a << sh;
		rv_isa_pkg::alu_srl:  return a >> sh;
		rv_isa_pkg::alu_sra:  return (a >> sh) | (a[31] ? ~(32'hFFFF_FFFF >> sh) : 32'h0);
		rv_isa_pkg::alu_slt:  return {31'b0, lt};
		rv_isa_pkg::alu_sltu: return {31'b0, (a < b)};
		default:              return 32'h0;
	endcase
endfunction

// Program order execution on a plain register array
task automatic run_model();
	rv_isa_pkg::word_t regs [rv_isa_pkg::NUM_REGS];
	rv_isa_pkg::word_t opb;
	for (int r = 0; r < rv_isa_pkg::NUM_REGS; r++) begin
		regs[r] = '0;
	end
	for (int i = 0; i < NUM_INST; i++) begin
		opb        = prog[i].use_imm ? prog[i].imm : regs[prog[i].rs2];
		exp_res[i] = alu_ref(prog[i].op, regs[prog[i].rs1], opb);
		if (prog[i].rd != '0) begin
			regs[prog[i].rd] = exp_res[i];                 // x0 stays zero
		end
	end
	for (int r = 0; r < rv_isa_pkg::NUM_REGS; r++) begin
		exp_regs[r] = regs[r];
	end
endtask

`endif

/* tb/tb_tomasulo_alu_core.sv */
`default_nettype none
`timescale 1ns/100ps

module tb_tomasulo_alu_core;

	localparam int RS_DEPTH      = 4;
	localparam int READY_TIMEOUT = 200;                 // Cycles waiting for inst_ready
	localparam int DRAIN_TIMEOUT = 500;
	localparam int BUSY_TIMEOUT  = 50;

	logic                  clk;
	logic                  rst;
	logic                  inst_valid;
	logic                  inst_use_imm;
	rv_isa_pkg::alu_op_e   inst_op;
	rv_isa_pkg::reg_addr_t inst_rd;
	rv_isa_pkg::reg_addr_t inst_rs1;
	rv_isa_pkg::reg_addr_t inst_rs2;
	rv_isa_pkg::word_t     inst_imm;
	logic                  inst_ready;
	logic                  cdb_valid;
	tomasulo_pkg::tag_t    cdb_tag;
	rv_isa_pkg::word_t     cdb_data;
	rv_isa_pkg::reg_addr_t reg_rd_addr;
	rv_isa_pkg::word_t     reg_rd_data;
	logic                  reg_rd_busy;

	`include "tb_stimulus.svh"

	// Scoreboard state
	int   cur_idx      = 0;                             // Entry on the input
	int   accept_count = 0;
	int   bcast_count  = 0;
	logic saw_stall    = 1'b0;                          // inst_ready low while valid
	logic tag_busy  [16];                               // Tags in flight
	int   tag_owner [16];                               // Program index per tag

	tomasulo_alu_core #(
		.RS_DEPTH (RS_DEPTH)
	) i_dut (
		.clk          (clk),
		.rst          (rst),
		.inst_valid   (inst_valid),
		.inst_use_imm (inst_use_imm),
		.inst_op      (inst_op),
		.inst_rd      (inst_rd),
		.inst_rs1     (inst_rs1),
		.inst_rs2     (inst_rs2),
		.inst_imm     (inst_imm),
		.inst_ready   (inst_ready),
		.cdb_valid    (cdb_valid),
		.cdb_tag      (cdb_tag),
		.cdb_data     (cdb_data),
		.reg_rd_addr  (reg_rd_addr),
		.reg_rd_data  (reg_rd_data),
		.reg_rd_busy  (reg_rd_busy)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;                           // 8 ns period
	end

	// ----------------------------------------------------------------------
	// Compare tasks
	// ----------------------------------------------------------------------

	task automatic check_word(input string name, input rv_isa_pkg::word_t got,
	                          input rv_isa_pkg::word_t exp);
		if (got !== exp) begin
			$display("Fail at %0t: %s = %h, expected %h", $time, name, got, exp);
			$display("TEST FAILED");
			$fatal(1, "Stopped on first mismatch");
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("Fail at %0t: %s = %b, expected %b", $time, name, got, exp);
			$display("TEST FAILED");
			$fatal(1, "Stopped on first mismatch");
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp) begin
			$display("Fail at %0t: %s = %0d, expected %0d", $time, name, got, exp);
			$display("TEST FAILED");
			$fatal(1, "Stopped on first mismatch");
		end
	endtask

	task automatic report_timeout(input string what);
		$display("Timed out at %0t while waiting for %s", $time, what);
		$display("TEST FAILED");
		$fatal(1, "Stopped on timeout");
	endtask

	// Lowest tag not in flight or zero when all are taken
	function automatic int lowest_free_tag();
		int idx;
		idx = 0;
		for (int t = RS_DEPTH; t >= 1; t--) begin
			if (!tag_busy[t]) begin
				idx = t;
			end
		end
		return idx;
	endfunction

	task automatic select_reg(input int r);
		@(negedge clk);
		reg_rd_addr = rv_isa_pkg::reg_addr_t'(r);
		#2;                                              // Read port settles by mid phase
	endtask

	// ----------------------------------------------------------------------
	// Bus monitor with tag allocation model
	// ----------------------------------------------------------------------

	always @(posedge clk) begin : bus_monitor
		int new_tag;
		if (rst) begin
			for (int t = 0; t < 16; t++) begin
				tag_busy[t] = 1'b0;
			end
		end else begin
			if (inst_valid && inst_ready) begin
				new_tag = lowest_free_tag();
				check_flag("free tag at acceptance", new_tag != 0, 1'b1);
				tag_busy[new_tag]  = 1'b1;
				tag_owner[new_tag] = cur_idx;
				accept_count++;
			end
			if (inst_valid && !inst_ready) begin
				saw_stall = 1'b1;
			end
			if (cdb_valid) begin
				check_flag("cdb_tag in range",
				           (cdb_tag != '0) && (int'(cdb_tag) <= RS_DEPTH), 1'b1);
				check_flag("cdb_tag in flight", tag_busy[cdb_tag], 1'b1);
				check_word("cdb_data", cdb_data, exp_res[tag_owner[cdb_tag]]);
				tag_busy[cdb_tag] = 1'b0;                  // Entry freed on its broadcast
				bcast_count++;
			end
			if (reg_rd_addr == '0) begin
				check_word("x0 value", reg_rd_data, '0);
				check_flag("x0 busy", reg_rd_busy, 1'b0);
			end
		end
	end

	// ----------------------------------------------------------------------
	// Main sequence
	// ----------------------------------------------------------------------

	initial begin : main_seq
		int unsigned seed;
		int          gap;
		int          waits;
		seed         = $urandom(97);
		rst          = 1'b1;
		inst_valid   = 1'b0;
		inst_use_imm = 1'b0;
		inst_op      = rv_isa_pkg::alu_add;
		inst_rd      = '0;
		inst_rs1     = '0;
		inst_rs2     = '0;
		inst_imm     = '0;
		reg_rd_addr  = '0;
		load_program();
		run_model();

		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		// State right after reset
		@(negedge clk);
		check_flag("inst_ready", inst_ready, 1'b1);
		check_flag("cdb_valid", cdb_valid, 1'b0);
		for (int r = 0; r < rv_isa_pkg::NUM_REGS; r++) begin
			select_reg(r);
			check_word("reg_rd_data", reg_rd_data, '0);
			check_flag("reg_rd_busy", reg_rd_busy, 1'b0);
		end
		@(negedge clk);
		reg_rd_addr = '0;                                // Watch x0 during the run

		for (int i = 0; i < NUM_INST; i++) begin
			cur_idx      = i;
			inst_valid   = 1'b1;
			inst_op      = prog[i].op;
			inst_rd      = prog[i].rd;
			inst_rs1     = prog[i].rs1;
			inst_rs2     = prog[i].rs2;
			inst_imm     = prog[i].imm;
			inst_use_imm = prog[i].use_imm;
			waits        = 0;
			while (!inst_ready) begin
				@(negedge clk);
				waits++;
				if (waits > READY_TIMEOUT) begin
					report_timeout("inst_ready");
				end
			end
			@(negedge clk);                              // Transfer at the edge between
			inst_valid = 1'b0;
			if (!prog[i].burst) begin
				gap = int'($urandom % 3);
				repeat (gap) @(negedge clk);
			end
		end

		// Every instruction broadcasts exactly once
		waits = 0;
		while (bcast_count < NUM_INST) begin
			@(negedge clk);
			waits++;
			if (waits > DRAIN_TIMEOUT) begin
				report_timeout("the remaining broadcasts");
			end
		end
		check_flag("inst_ready stall seen", saw_stall, 1'b1);

		// Final architectural state against the model
		for (int r = 0; r < rv_isa_pkg::NUM_REGS; r++) begin
			select_reg(r);
			waits = 0;
			while (reg_rd_busy) begin
				@(negedge clk);
				#2;
				waits++;
				if (waits > BUSY_TIMEOUT) begin
					report_timeout("a register to leave busy");
				end
			end
			check_word($sformatf("x%0d", r), reg_rd_data, exp_regs[r]);
		end

		// No stray broadcast during the read-back
		check_count("broadcast count", bcast_count, accept_count);

		$display("TEST PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* hw/tomasulo_alu_core.sv */
`default_nettype none
`timescale 1ns/100ps

module tomasulo_alu_core #(
	parameter int RS_DEPTH = 4                           // Station entries
) (
	input  logic                  clk,
	input  logic                  rst,
	// Decoded instruction input
	input  logic                  inst_valid,
	input  logic                  inst_use_imm,
	input  rv_isa_pkg::alu_op_e   inst_op,
	input  rv_isa_pkg::reg_addr_t inst_rd,
	input  rv_isa_pkg::reg_addr_t inst_rs1,
	input  rv_isa_pkg::reg_addr_t inst_rs2,
	input  rv_isa_pkg::word_t     inst_imm,
	output logic                  inst_ready,
	// Result broadcast
	output logic                  cdb_valid,
	output tomasulo_pkg::tag_t    cdb_tag,
	output rv_isa_pkg::word_t     cdb_data,
	// Register read-back
	input  rv_isa_pkg::reg_addr_t reg_rd_addr,
	output rv_isa_pkg::word_t     reg_rd_data,
	output logic                  reg_rd_busy
);

	// ----------------------------------------------------------------------
	// Issue and dispatch wiring
	// ----------------------------------------------------------------------

	logic                issue_valid;
	rv_isa_pkg::alu_op_e issue_op;
	tomasulo_pkg::tag_t  issue_q1;
	tomasulo_pkg::tag_t  issue_q2;
	rv_isa_pkg::word_t   issue_v1;
	rv_isa_pkg::word_t   issue_v2;
	logic                issue_ready;                  // Station has room
	tomasulo_pkg::tag_t  issue_tag;                    // Rename tag for rd

	logic                disp_valid;                   // Valid only, ALU never stalls
	rv_isa_pkg::alu_op_e disp_op;
	rv_isa_pkg::word_t   disp_a;
	rv_isa_pkg::word_t   disp_b;
	tomasulo_pkg::tag_t  disp_tag;

	// Rename and issue
	rename_issue i_rename (
		.clk          (clk),
		.rst          (rst),
		.inst_valid   (inst_valid),
		.inst_use_imm (inst_use_imm),
		.inst_op      (inst_op),
		.inst_rd      (inst_rd),
		.inst_rs1     (inst_rs1),
		.inst_rs2     (inst_rs2),
		.inst_imm     (inst_imm),
		.inst_ready   (inst_ready),
		.issue_valid  (issue_valid),
		.issue_op     (issue_op),
		.issue_q1     (issue_q1),
		.issue_q2     (issue_q2),
		.issue_v1     (issue_v1),
		.issue_v2     (issue_v2),
		.issue_ready  (issue_ready),
		.issue_tag    (issue_tag),
		.cdb_valid    (cdb_valid),                     // Bus snoop
		.cdb_tag      (cdb_tag),
		.cdb_data     (cdb_data),
		.reg_rd_addr  (reg_rd_addr),
		.reg_rd_data  (reg_rd_data),
		.reg_rd_busy  (reg_rd_busy)
	);

	// Waiting instructions
	reservation_station #(
		.RS_DEPTH (RS_DEPTH)
	) i_rs (
		.clk         (clk),
		.rst         (rst),
		.issue_valid (issue_valid),
		.issue_op    (issue_op),
		.issue_q1    (issue_q1),
		.issue_q2    (issue_q2),
		.issue_v1    (issue_v1),
		.issue_v2    (issue_v2),
		.issue_ready (issue_ready),
		.issue_tag   (issue_tag),
		.cdb_valid   (cdb_valid),
		.cdb_tag     (cdb_tag),
		.cdb_data    (cdb_data),
		.disp_valid  (disp_valid),
		.disp_op     (disp_op),
		.disp_a      (disp_a),
		.disp_b      (disp_b),
		.disp_tag    (disp_tag)
	);

	// Single writer of the bus
	alu_exec i_alu (
		.clk        (clk),
		.rst        (rst),
		.disp_valid (disp_valid),
		.disp_op    (disp_op),
		.disp_a     (disp_a),
		.disp_b     (disp_b),
		.disp_tag   (disp_tag),
		.cdb_valid  (cdb_valid),
		.cdb_tag    (cdb_tag),
		.cdb_data   (cdb_data)
	);

endmodule

`default_nettype wire

/* hw/alu_exec.sv */
`default_nettype none
`timescale 1ns/100ps

module alu_exec (
	input  logic                clk,
	input  logic                rst,
	// Dispatch from the station
	input  logic                disp_valid,
	input  rv_isa_pkg::alu_op_e disp_op,
	input  rv_isa_pkg::word_t   disp_a,
	input  rv_isa_pkg::word_t   disp_b,
	input  tomasulo_pkg::tag_t  disp_tag,
	// Common data bus
	output logic                cdb_valid,
	output tomasulo_pkg::tag_t  cdb_tag,
	output rv_isa_pkg::word_t   cdb_data
);

	localparam int res_regs = tomasulo_pkg::ALU_STAGES - 1;  // Registers after stage one

	logic                s1_valid;                     // Operand stage
	rv_isa_pkg::alu_op_e s1_op;
	rv_isa_pkg::word_t   s1_a;
	rv_isa_pkg::word_t   s1_b;
	tomasulo_pkg::tag_t  s1_tag;

	rv_isa_pkg::shamt_t  shamt;
	rv_isa_pkg::word_t   result;

	logic                res_valid [res_regs];         // Result stages
	tomasulo_pkg::tag_t  res_tag   [res_regs];
	rv_isa_pkg::word_t   res_data  [res_regs];

	// ----------------------------------------------------------------------
	// Compute
	// ----------------------------------------------------------------------

	assign shamt = s1_b[rv_isa_pkg::SHAMT_W-1:0];          // RV32 uses low 5 bits

	always_comb begin
		case (s1_op)
			rv_isa_pkg::alu_add:  result = s1_a + s1_b;
			rv_isa_pkg::alu_sub:  result = s1_a - s1_b;
			rv_isa_pkg::alu_and:  result = s1_a & s1_b;
			rv_isa_pkg::alu_or:   result = s1_a | s1_b;
			rv_isa_pkg::alu_xor:  result = s1_a ^ s1_b;
			rv_isa_pkg::alu_sll:  result = s1_a << shamt;
			rv_isa_pkg::alu_srl:  result = s1_a >> shamt;
			rv_isa_pkg::alu_sra:  result = rv_isa_pkg::word_t'($signed(s1_a) >>> shamt);
			rv_isa_pkg::alu_slt:  result = rv_isa_pkg::word_t'($signed(s1_a) < $signed(s1_b));
			rv_isa_pkg::alu_sltu: result = rv_isa_pkg::word_t'(s1_a < s1_b);
			default:              result = '0;         // Unused encodings
		endcase
	end

	// ----------------------------------------------------------------------
	// Pipeline registers
	// ----------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (rst) begin
			s1_valid <= 1'b0;
			for (int k = 0; k < res_regs; k++) begin
				res_valid[k] <= 1'b0;
			end
		end else begin
			s1_valid     <= disp_valid;                // Never stalls
			res_valid[0] <= s1_valid;
			for (int k = 1; k < res_regs; k++) begin
				res_valid[k] <= res_valid[k-1];
			end
		end
	end

	always_ff @(posedge clk) begin
		s1_op       <= disp_op;
		s1_a        <= disp_a;
		s1_b        <= disp_b;
		s1_tag      <= disp_tag;
		res_tag[0]  <= s1_tag;
		res_data[0] <= result;
		for (int k = 1; k < res_regs; k++) begin
			res_tag[k]  <= res_tag[k-1];
			res_data[k] <= res_data[k-1];
		end
	end

	// Last stage drives the bus
	assign cdb_valid = res_valid[res_regs-1];
	assign cdb_tag   = res_tag[res_regs-1];
	assign cdb_data  = res_data[res_regs-1];

endmodule

`default_nettype wire

/* hw/reservation_station.sv */
`default_nettype none
`timescale 1ns/100ps

module reservation_station #(
	parameter int RS_DEPTH = 4                           // Entry count
) (
	input  logic                clk,
	input  logic                rst,
	// Issue from rename
	input  logic                issue_valid,
	input  rv_isa_pkg::alu_op_e issue_op,
	input  tomasulo_pkg::tag_t  issue_q1,
	input  tomasulo_pkg::tag_t  issue_q2,
	input  rv_isa_pkg::word_t   issue_v1,
	input  rv_isa_pkg::word_t   issue_v2,
	output logic                issue_ready,
	output tomasulo_pkg::tag_t  issue_tag,
	// Common data bus
	input  logic                cdb_valid,
	input  tomasulo_pkg::tag_t  cdb_tag,
	input  rv_isa_pkg::word_t   cdb_data,
	// Dispatch to the ALU
	output logic                disp_valid,
	output rv_isa_pkg::alu_op_e disp_op,
	output rv_isa_pkg::word_t   disp_a,
	output rv_isa_pkg::word_t   disp_b,
	output tomasulo_pkg::tag_t  disp_tag
);

	// Never more entries than tags can name
	localparam int n_entries = (RS_DEPTH < tomasulo_pkg::MAX_RS_DEPTH) ?
	                           RS_DEPTH : tomasulo_pkg::MAX_RS_DEPTH;

	// ----------------------------------------------------------------------
	// Entry storage
	// ----------------------------------------------------------------------

	logic                busy       [n_entries];       // Holds an instruction
	logic                dispatched [n_entries];       // Sent to ALU, result pending
	rv_isa_pkg::alu_op_e op         [n_entries];
	tomasulo_pkg::tag_t  q1         [n_entries];       // Operand a producer
	tomasulo_pkg::tag_t  q2         [n_entries];       // Operand b producer
	rv_isa_pkg::word_t   v1         [n_entries];
	rv_isa_pkg::word_t   v2         [n_entries];

	logic [n_entries-1:0] free_vec;
	logic [n_entries-1:0] ready_vec;
	int                   free_idx;                    // Lowest free entry
	int                   disp_idx;                    // Lowest ready entry
	logic                 issue_fire;

	// Index of the lowest set request bit
	function automatic int lowest_index(input logic [n_entries-1:0] req);
		int idx;
		idx = 0;
		for (int i = n_entries - 1; i >= 0; i--) begin
			if (req[i]) begin
				idx = i;
			end
		end
		return idx;
	endfunction

	// ----------------------------------------------------------------------
	// Priority finders
	// ----------------------------------------------------------------------

	always_comb begin
		for (int i = 0; i < n_entries; i++) begin
			free_vec[i]  = ~busy[i];
			ready_vec[i] = busy[i] & ~dispatched[i] &
			               (q1[i] == tomasulo_pkg::TAG_NONE) &
			               (q2[i] == tomasulo_pkg::TAG_NONE);   // Both operands in hand
		end
	end

	assign free_idx    = lowest_index(free_vec);
	assign disp_idx    = lowest_index(ready_vec);

	assign issue_ready = |free_vec;
	assign issue_tag   = tomasulo_pkg::tag_t'(free_idx + 1);  // Tag is index plus one
	assign issue_fire  = issue_valid & issue_ready;

	assign disp_valid  = |ready_vec;
	assign disp_op     = op[disp_idx];
	assign disp_a      = v1[disp_idx];
	assign disp_b      = v2[disp_idx];
	assign disp_tag    = tomasulo_pkg::tag_t'(disp_idx + 1);

	// ----------------------------------------------------------------------
	// Entry control
	// ----------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < n_entries; i++) begin
				busy[i]       <= 1'b0;
				dispatched[i] <= 1'b0;
			end
		end else begin
			for (int i = 0; i < n_entries; i++) begin
				if (busy[i] && cdb_valid && (cdb_tag == tomasulo_pkg::tag_t'(i + 1))) begin
					busy[i] <= 1'b0;                       // Own result broadcast, tag free
				end
			end
			if (disp_valid) begin
				dispatched[disp_idx] <= 1'b1;
			end
			if (issue_fire) begin
				busy[free_idx]       <= 1'b1;
				dispatched[free_idx] <= 1'b0;
			end
		end
	end

	// Operand capture and entry write
	always_ff @(posedge clk) begin
		for (int i = 0; i < n_entries; i++) begin
			if (busy[i] && cdb_valid) begin
				if ((q1[i] != tomasulo_pkg::TAG_NONE) && (q1[i] == cdb_tag)) begin
					q1[i] <= tomasulo_pkg::TAG_NONE;
					v1[i] <= cdb_data;
				end
				if ((q2[i] != tomasulo_pkg::TAG_NONE) && (q2[i] == cdb_tag)) begin
					q2[i] <= tomasulo_pkg::TAG_NONE;
					v2[i] <= cdb_data;
				end
			end
		end
		if (issue_fire) begin
			op[free_idx] <= issue_op;                      // Operands already bypassed
			q1[free_idx] <= issue_q1;
			q2[free_idx] <= issue_q2;
			v1[free_idx] <= issue_v1;
			v2[free_idx] <= issue_v2;
		end
	end

endmodule

`default_nettype wire

/* hw/rename_issue.sv */
`default_nettype none
`timescale 1ns/100ps

module rename_issue (
	input  logic                  clk,
	input  logic                  rst,
	// Decoded instruction from the source
	input  logic                  inst_valid,
	input  logic                  inst_use_imm,        // Operand b is the immediate
	input  rv_isa_pkg::alu_op_e   inst_op,
	input  rv_isa_pkg::reg_addr_t inst_rd,
	input  rv_isa_pkg::reg_addr_t inst_rs1,
	input  rv_isa_pkg::reg_addr_t inst_rs2,
	input  rv_isa_pkg::word_t     inst_imm,
	output logic                  inst_ready,
	// Issue towards the reservation station
	output logic                  issue_valid,
	output rv_isa_pkg::alu_op_e   issue_op,
	output tomasulo_pkg::tag_t    issue_q1,
	output tomasulo_pkg::tag_t    issue_q2,
	output rv_isa_pkg::word_t     issue_v1,
	output rv_isa_pkg::word_t     issue_v2,
	input  logic                  issue_ready,         // Free entry available
	input  tomasulo_pkg::tag_t    issue_tag,           // Tag of that entry
	// Common data bus
	input  logic                  cdb_valid,
	input  tomasulo_pkg::tag_t    cdb_tag,
	input  rv_isa_pkg::word_t     cdb_data,
	// Read-back port
	input  rv_isa_pkg::reg_addr_t reg_rd_addr,
	output rv_isa_pkg::word_t     reg_rd_data,
	output logic                  reg_rd_busy
);

	// ----------------------------------------------------------------------
	// Tagged register file
	// ----------------------------------------------------------------------

	rv_isa_pkg::word_t  reg_val [rv_isa_pkg::NUM_REGS];    // Committed values
	tomasulo_pkg::tag_t reg_tag [rv_isa_pkg::NUM_REGS];    // Pending producer

	logic               accept;                            // Handshake this cycle
	tomasulo_pkg::tag_t rs1_tag;
	tomasulo_pkg::tag_t rs2_tag;
	logic               rs1_hit;                           // rs1 producer on the bus now
	logic               rs2_hit;

	// Ready simply mirrors the station
	assign inst_ready  = issue_ready;
	assign issue_valid = inst_valid;
	assign issue_op    = inst_op;
	assign accept      = inst_valid & issue_ready;

	// ----------------------------------------------------------------------
	// Operand read with same-cycle bus bypass
	// ----------------------------------------------------------------------

	assign rs1_tag = reg_tag[inst_rs1];
	assign rs2_tag = reg_tag[inst_rs2];

	assign rs1_hit = cdb_valid && (rs1_tag != tomasulo_pkg::TAG_NONE) && (rs1_tag == cdb_tag);
	assign rs2_hit = cdb_valid && (rs2_tag != tomasulo_pkg::TAG_NONE) && (rs2_tag == cdb_tag);

	assign issue_q1 = rs1_hit ? tomasulo_pkg::TAG_NONE : rs1_tag;
	assign issue_v1 = rs1_hit ? cdb_data : reg_val[inst_rs1];

	// Immediate always counts as resolved
	assign issue_q2 = (inst_use_imm || rs2_hit) ? tomasulo_pkg::TAG_NONE : rs2_tag;
	assign issue_v2 = inst_use_imm ? inst_imm :
	                  rs2_hit      ? cdb_data : reg_val[inst_rs2];

	// ----------------------------------------------------------------------
	// Rename and writeback
	// ----------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < rv_isa_pkg::NUM_REGS; i++) begin
				reg_val[i] <= '0;                          // Architectural state cleared
				reg_tag[i] <= tomasulo_pkg::TAG_NONE;
			end
		end else begin
			// x0 is never touched
			for (int i = 1; i < rv_isa_pkg::NUM_REGS; i++) begin
				if (cdb_valid && (reg_tag[i] != tomasulo_pkg::TAG_NONE) &&
				    (reg_tag[i] == cdb_tag)) begin
					reg_val[i] <= cdb_data;                // Producer finished
					reg_tag[i] <= tomasulo_pkg::TAG_NONE;
				end
			end
			if (accept && (inst_rd != '0)) begin
				reg_tag[inst_rd] <= issue_tag;             // Later write wins over bus clear
			end
		end
	end

	// Combinational read-back
	assign reg_rd_data = reg_val[reg_rd_addr];
	assign reg_rd_busy = (reg_tag[reg_rd_addr] != tomasulo_pkg::TAG_NONE);

endmodule

`default_nettype wire

/* hw/tomasulo_pkg.sv */
`default_nettype none

// --------------------------------------------------------------------------
// Renaming and scheduling types
// --------------------------------------------------------------------------

package tomasulo_pkg;

	localparam int TAG_W = 4;                            // Rename tag width

	typedef logic [TAG_W-1:0] tag_t;                     // Tag k names entry k-1

	localparam tag_t TAG_NONE = '0;                      // Value present, no producer

	// Tag zero is reserved, so one less than the tag space
	localparam int MAX_RS_DEPTH = (1 << TAG_W) - 1;

	localparam int ALU_STAGES = 2;                       // ALU pipeline registers

endpackage

`default_nettype wire

/* hw/rv_isa_pkg.sv */
`default_nettype none

// --------------------------------------------------------------------------
// ISA level types shared by the core and its instruction source
// --------------------------------------------------------------------------

package rv_isa_pkg;

	localparam int XLEN     = 32;                        // Data path width
	localparam int NUM_REGS = 32;                        // x0 to x31
	localparam int SHAMT_W  = 5;                         // RV32 shift amount bits

	typedef logic [XLEN-1:0]             word_t;         // Register or operand value
	typedef logic [$clog2(NUM_REGS)-1:0] reg_addr_t;     // Architectural register index
	typedef logic [SHAMT_W-1:0]          shamt_t;        // Low bits of operand b

	// Integer ALU operations from the decoder
	typedef enum logic [3:0] {
		alu_add  = 4'd0,                                 // a + b
		alu_sub  = 4'd1,                                 // a - b
		alu_and  = 4'd2,
		alu_or   = 4'd3,
		alu_xor  = 4'd4,
		alu_sll  = 4'd5,                                 // Logical left
		alu_srl  = 4'd6,                                 // Logical right
		alu_sra  = 4'd7,                                 // Arithmetic right
		alu_slt  = 4'd8,                                 // Signed compare
		alu_sltu = 4'd9                                  // Unsigned compare
	} alu_op_e;

endpackage

`default_nettype wire
